/* pcxt_cfg_pkg.sv */
`default_nettype none

package pcxt_cfg_pkg;

	//////////////////////////////
	// OSD status word bit map
	//////////////////////////////

	// Single-bit fields
	localparam logic [4:0] st_soft_reset  = 5'd0;
	localparam logic [4:0] st_model       = 5'd3;
	localparam logic [4:0] st_video_card  = 5'd4;
	localparam logic [4:0] st_splash_skip = 5'd7;
	localparam logic [4:0] st_adlib_hide  = 5'd10;
	localparam logic [4:0] st_ems_disable = 5'd11;
	localparam logic [4:0] st_covox       = 5'd18;

	// Low bit of multi-bit fields
	localparam logic [4:0] st_aspect_lo    = 5'd8;
	localparam logic [4:0] st_ems_frame_lo = 5'd12;
	localparam logic [4:0] st_tint_lo      = 5'd14;

	// Download slot that carries the BIOS image
	localparam logic [7:0] bios_index = 8'd0;

	// PC/XT DIP switches, CGA 80 col or MDA
	localparam logic [7:0] dip_cga = 8'h2D;
	localparam logic [7:0] dip_mda = 8'h3D;

	// HDMI aspect port width
	localparam int aspect_w = 13;

	//////////////////////////////
	// Machine setting types
	//////////////////////////////

	typedef enum logic [0:0] {ibm_xt, tandy_1000} machine_model_e;

	typedef enum logic [0:0] {cga, mda} video_card_e;

	// Monochrome tint, order matches the menu
	typedef enum logic [2:0] {
		full_color, green, amber, black_white, red, blue, fuchsia, purple
	} display_tint_e;

	typedef enum logic [1:0] {frame_a000, frame_c000, frame_d000} ems_frame_e;

endpackage

`default_nettype wire

/* pcxt_timing_pkg.sv */
`default_nettype none

package pcxt_timing_pkg;

	//////////////////////////////
	// Clock and audio rates
	//////////////////////////////

	// Board oscillator
	localparam logic [31:0] sys_clock_hz = 32'd50_000_000;

	// Sample rate of the mixer clock-enable
	localparam logic [31:0] audio_rate_hz = 32'd44100;

	//////////////////////////////
	// Reset and splash timing
	//////////////////////////////

	// System reset stretch after last request, in clocks
	localparam logic [15:0] reset_hold_cycles = 16'd64;

	// Extra clocks the CPU stays in reset
	localparam logic [15:0] cpu_reset_delay = 16'd42;

	// Splash hold time in whole seconds
	localparam logic [3:0] splash_seconds = 4'd5;

endpackage

`default_nettype wire

/* status_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module status_decode import pcxt_cfg_pkg::*; (
	input  wire logic [31:0]         status,
	input  wire logic                user_button,
	input  wire logic                ioctl_download,
	input  wire logic [7:0]          ioctl_index,
	input  wire logic [7:0]          port_b_out,
	output logic [aspect_w-1:0]      video_arx,
	output logic [aspect_w-1:0]      video_ary,
	output machine_model_e           machine_model,
	output video_card_e              video_card,
	output display_tint_e            display_tint,
	output logic                     ems_enable,
	output ems_frame_e               ems_frame,
	output logic                     adlib_hide,
	output logic                     covox_enable,
	output logic                     splash_skip,
	output logic [3:0]               port_c_low,
	output logic                     reset_request
);

	logic [1:0] aspect_field;
	logic [1:0] frame_field;
	logic [7:0] dip_byte;
	logic       bios_load;

	//////////////////////////////
	// Video settings
	//////////////////////////////

	assign aspect_field = status[st_aspect_lo +: 2];

	// Original 4:3, otherwise full screen or one of the ARC slots
	always_comb begin
		case (aspect_field)
			2'd0: begin
				video_arx = aspect_w'(4);
				video_ary = aspect_w'(3);
			end
			2'd1: begin
				video_arx = '0;
				video_ary = '0;
			end
			2'd2: begin
				video_arx = aspect_w'(1);
				video_ary = '0;
			end
			default: begin
				video_arx = aspect_w'(2);
				video_ary = '0;
			end
		endcase
	end

	assign video_card   = video_card_e'(status[st_video_card]);
	assign display_tint = display_tint_e'(status[st_tint_lo +: 3]);

	//////////////////////////////
	// Hardware settings
	//////////////////////////////

	assign machine_model = machine_model_e'(status[st_model]);

	// Menu bit is a disable
	assign ems_enable  = ~status[st_ems_disable];
	assign frame_field = status[st_ems_frame_lo +: 2];

	// Unused code 3 falls back to D000
	always_comb begin
		case (frame_field)
			2'd0:    ems_frame = frame_a000;
			2'd1:    ems_frame = frame_c000;
			default: ems_frame = frame_d000;
		endcase
	end

	assign adlib_hide   = status[st_adlib_hide];
	assign covox_enable = status[st_covox];
	assign splash_skip  = status[st_splash_skip];

	// PPI port C reads one DIP nibble, chosen by port B bit 3
	assign dip_byte   = (video_card == mda) ? dip_mda : dip_cga;
	assign port_c_low = port_b_out[3] ? dip_byte[7:4] : dip_byte[3:0];

	// Soft reset, user key or a BIOS reload
	assign bios_load     = ioctl_download && (ioctl_index == bios_index);
	assign reset_request = status[st_soft_reset] | user_button | bios_load;

endmodule

`default_nettype wire

/* splash_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module splash_timer import pcxt_timing_pkg::*; #(
	parameter int unsigned ticks_per_second = sys_clock_hz
) (
	input  wire logic CLK_50M,
	input  wire logic reset_wire,
	input  wire logic splash_skip,
	output logic      splash_active
);

	// Tick counter width, at least one bit
	localparam int tick_w = (ticks_per_second > 1) ? $clog2(ticks_per_second) : 1;
	localparam logic [tick_w-1:0] tick_last = tick_w'(ticks_per_second - 1);

	logic [tick_w-1:0] tick_cnt;
	logic [3:0]        sec_cnt;

	// Counts only while the splash is shown
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active <= 1'b1;
			tick_cnt      <= '0;
			sec_cnt       <= '0;
		end else if (splash_active) begin
			if (splash_skip) begin
				// Skip drops the screen on the next edge
				splash_active <= 1'b0;
			end else if (tick_cnt == tick_last) begin
				tick_cnt <= '0;
				// Last second elapsed
				if (sec_cnt == splash_seconds - 4'd1) begin
					splash_active <= 1'b0;
				end else begin
					sec_cnt <= sec_cnt + 4'd1;
				end
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* reset_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer import pcxt_timing_pkg::*; (
	input  wire logic CLK_50M,
	input  wire logic reset_wire,
	input  wire logic reset_request,
	input  wire logic splash_active,
	output logic      sys_reset,
	output logic      cpu_reset
);

	logic        any_request;
	logic [15:0] hold_cnt;
	logic [15:0] cpu_cnt;

	// Splash screen keeps the machine parked in reset
	assign any_request = reset_request | splash_active;

	//////////////////////////////
	// Chained reset counters
	//////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset <= 1'b1;
			cpu_reset <= 1'b1;
			hold_cnt  <= '0;
			cpu_cnt   <= '0;
		end else if (any_request) begin
			// Restart both stages
			sys_reset <= 1'b1;
			cpu_reset <= 1'b1;
			hold_cnt  <= '0;
			cpu_cnt   <= '0;
		end else if (sys_reset) begin
			// First stage, system reset stretch
			if (hold_cnt == reset_hold_cycles - 16'd1) begin
				sys_reset <= 1'b0;
			end else begin
				hold_cnt <= hold_cnt + 16'd1;
			end
		end else if (cpu_reset) begin
			// Second stage starts once the chipset is out of reset
			if (cpu_cnt == cpu_reset_delay - 16'd1) begin
				cpu_reset <= 1'b0;
			end else begin
				cpu_cnt <= cpu_cnt + 16'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* audio_tick_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module audio_tick_gen import pcxt_timing_pkg::*; (
	input  wire logic CLK_50M,
	input  wire logic reset_wire,
	output logic      audio_ce
);

	logic [31:0] phase_acc;
	logic [31:0] phase_next;
	logic        wrap;

	// Phase step per clock
	assign phase_next = phase_acc + audio_rate_hz;
	assign wrap       = (phase_next >= sys_clock_hz);

	// Remainder carried over keeps the long-term rate exact
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			phase_acc <= '0;
			audio_ce  <= 1'b0;
		end else begin
			audio_ce <= wrap;
			if (wrap) begin
				phase_acc <= phase_next - sys_clock_hz;
			end else begin
				phase_acc <= phase_next;
			end
		end
	end

endmodule

`default_nettype wire

/* sd_route.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_route (
	input  wire logic        CLK_50M,
	input  wire logic        reset_wire,
	input  wire logic        img_mounted,
	input  wire logic [63:0] img_size,
	input  wire logic        spi_cs,
	input  wire logic        spi_sck,
	input  wire logic        spi_mosi,
	input  wire logic        sd_miso,
	input  wire logic        vsd_miso,
	output logic             spi_miso,
	output logic             sd_cs,
	output logic             sd_sck,
	output logic             sd_mosi,
	output logic             vsd_cs
);

	// High when a disk image is mounted
	logic vsd_sel;

	// Empty image means unmount, back to the real card
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			vsd_sel <= 1'b0;
		end else if (img_mounted) begin
			vsd_sel <= |img_size;
		end
	end

	//////////////////////////////
	// SPI steering
	//////////////////////////////

	// Physical card idle while the image is in use
	assign sd_cs   = spi_cs | vsd_sel;
	assign sd_sck  = spi_sck & ~vsd_sel;
	assign sd_mosi = spi_mosi & ~vsd_sel;

	// Virtual card only selected with an image
	assign vsd_cs = spi_cs | ~vsd_sel;

	assign spi_miso = vsd_sel ? vsd_miso : sd_miso;

endmodule

`default_nettype wire

/* pcxt_glue_top.sv */
`timescale 1ns/10ps
`default_nettype none

module pcxt_glue_top import pcxt_cfg_pkg::*, pcxt_timing_pkg::*; #(
	parameter int unsigned ticks_per_second = sys_clock_hz
) (
	input  wire logic                CLK_50M,
	input  wire logic                reset_wire,
	// OSD and host side
	input  wire logic [31:0]         status,
	input  wire logic                user_button,
	input  wire logic                ioctl_download,
	input  wire logic [7:0]          ioctl_index,
	input  wire logic [7:0]          port_b_out,
	output logic [aspect_w-1:0]      video_arx,
	output logic [aspect_w-1:0]      video_ary,
	output machine_model_e           machine_model,
	output video_card_e              video_card,
	output display_tint_e            display_tint,
	output logic                     ems_enable,
	output ems_frame_e               ems_frame,
	output logic                     adlib_hide,
	output logic                     covox_enable,
	output logic [3:0]               port_c_low,
	// Resets and audio enable
	output logic                     sys_reset,
	output logic                     cpu_reset,
	output logic                     audio_ce,
	// SD card paths
	input  wire logic                img_mounted,
	input  wire logic [63:0]         img_size,
	input  wire logic                spi_cs,
	input  wire logic                spi_sck,
	input  wire logic                spi_mosi,
	input  wire logic                sd_miso,
	input  wire logic                vsd_miso,
	output logic                     spi_miso,
	output logic                     sd_cs,
	output logic                     sd_sck,
	output logic                     sd_mosi,
	output logic                     vsd_cs
);

	logic reset_request;
	logic splash_skip;
	logic splash_active;

	//////////////////////////////
	// Menu decode
	//////////////////////////////

	status_decode u_status_decode (
		.status         (status),
		.user_button    (user_button),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.port_b_out     (port_b_out),
		.video_arx      (video_arx),
		.video_ary      (video_ary),
		.machine_model  (machine_model),
		.video_card     (video_card),
		.display_tint   (display_tint),
		.ems_enable     (ems_enable),
		.ems_frame      (ems_frame),
		.adlib_hide     (adlib_hide),
		.covox_enable   (covox_enable),
		.splash_skip    (splash_skip),
		.port_c_low     (port_c_low),
		.reset_request  (reset_request)
	);

	//////////////////////////////
	// Timers and SD routing
	//////////////////////////////

	splash_timer #(
		.ticks_per_second (ticks_per_second)
	) u_splash_timer (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.splash_skip   (splash_skip),
		.splash_active (splash_active)
	);

	// Splash hold feeds the reset chain
	reset_sequencer u_reset_sequencer (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.reset_request (reset_request),
		.splash_active (splash_active),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset)
	);

	audio_tick_gen u_audio_tick_gen (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.audio_ce   (audio_ce)
	);

	sd_route u_sd_route (
		.CLK_50M     (CLK_50M),
		.reset_wire  (reset_wire),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.spi_cs      (spi_cs),
		.spi_sck     (spi_sck),
		.spi_mosi    (spi_mosi),
		.sd_miso     (sd_miso),
		.vsd_miso    (vsd_miso),
		.spi_miso    (spi_miso),
		.sd_cs       (sd_cs),
		.sd_sck      (sd_sck),
		.sd_mosi     (sd_mosi),
		.vsd_cs      (vsd_cs)
	);

endmodule

`default_nettype wire

/* tb_pcxt_glue.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_pcxt_glue import pcxt_cfg_pkg::*, pcxt_timing_pkg::*; ();

	// Short seconds so the splash hold fits a quick run
	localparam int unsigned sim_ticks = 200;

	logic CLK_50M;
	logic reset_wire;
	logic [31:0] status;
	logic user_button;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic [7:0] port_b_out;
	logic [aspect_w-1:0] video_arx;
	logic [aspect_w-1:0] video_ary;
	machine_model_e machine_model;
	video_card_e video_card;
	display_tint_e display_tint;
	logic ems_enable;
	ems_frame_e ems_frame;
	logic adlib_hide;
	logic covox_enable;
	logic [3:0] port_c_low;
	logic sys_reset;
	logic cpu_reset;
	logic audio_ce;
	logic img_mounted;
	logic [63:0] img_size;
	logic spi_cs;
	logic spi_sck;
	logic spi_mosi;
	logic sd_miso;
	logic vsd_miso;
	logic spi_miso;
	logic sd_cs;
	logic sd_sck;
	logic sd_mosi;
	logic vsd_cs;
	integer seed;

	pcxt_glue_top #(
		.ticks_per_second (sim_ticks)
	) u_pcxt_glue_top (
		.CLK_50M(CLK_50M), .reset_wire(reset_wire), .status(status),
		.user_button(user_button), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .port_b_out(port_b_out),
		.video_arx(video_arx), .video_ary(video_ary), .machine_model(machine_model),
		.video_card(video_card), .display_tint(display_tint), .ems_enable(ems_enable),
		.ems_frame(ems_frame), .adlib_hide(adlib_hide), .covox_enable(covox_enable),
		.port_c_low(port_c_low), .sys_reset(sys_reset), .cpu_reset(cpu_reset),
		.audio_ce(audio_ce), .img_mounted(img_mounted), .img_size(img_size),
		.spi_cs(spi_cs), .spi_sck(spi_sck), .spi_mosi(spi_mosi), .sd_miso(sd_miso),
		.vsd_miso(vsd_miso), .spi_miso(spi_miso), .sd_cs(sd_cs), .sd_sck(sd_sck),
		.sd_mosi(sd_mosi), .vsd_cs(vsd_cs)
	);

	// 50 MHz board clock
	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task report_failure(input string why);
		$display("STATUS: FAIL");
		$display("%s", why);
		$fatal(1, "run aborted");
	endtask

	task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
			report_failure($sformatf("Error %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// Hold reset for 16 clocks and release on a rising edge
	task apply_reset();
		@(posedge CLK_50M);
		reset_wire <= 1'b1;
		repeat (16) @(posedge CLK_50M);
		reset_wire <= 1'b0;
	endtask

	// Counts falling edges until the chosen reset reaches a level
	task wait_reset_level(input bit pick_cpu, input logic level, input int limit,
		output int cycles);
		cycles = 0;
		while ((pick_cpu ? cpu_reset : sys_reset) !== level) begin
			@(negedge CLK_50M);
			cycles++;
			if (cycles > limit)
				report_failure($sformatf("Timed out waiting for %s to reach %0d",
					pick_cpu ? "cpu_reset" : "sys_reset", level));
		end
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	// Skip bit set so the splash ends at once
	task skipped_splash_release();
		int n;
		@(posedge CLK_50M);
		status <= 32'h1 << st_splash_skip;
		apply_reset();
		wait_reset_level(1'b0, 1'b0, 200, n);
		check_value("sys_reset release cycle",
			n, (n >= reset_hold_cycles && n <= reset_hold_cycles + 2) ? n : reset_hold_cycles);
		wait_reset_level(1'b1, 1'b0, 200, n);
		check_value("cpu_reset delay after sys_reset", n, cpu_reset_delay);
	endtask

	task splash_hold_time();
		int n;
		int min_hold;
		min_hold = splash_seconds * sim_ticks + reset_hold_cycles;
		@(posedge CLK_50M);
		status <= 32'h0;
		apply_reset();
		wait_reset_level(1'b0, 1'b0, min_hold + 200, n);
		check_value("sys_reset hold cycles", n, (n >= min_hold) ? n : min_hold);
		wait_reset_level(1'b1, 1'b0, 200, n);
	endtask

	// Expected settings straight from the bit map
	task decode_settings();
		logic [31:0] s;
		logic [7:0] pb_val;
		logic [7:0] dip;
		logic [12:0] ex_arx;
		logic [12:0] ex_ary;
		logic [1:0] ex_frame;
		for (int i = 0; i < 24; i++) begin
			s = $random(seed);
			// Force the unused EMS frame code now and then
			if (i % 4 == 0)
				s[13:12] = 2'b11;
			for (int pb = 0; pb < 2; pb++) begin
				pb_val = $random(seed);
				pb_val[3] = pb[0];
				@(posedge CLK_50M);
				status <= s;
				port_b_out <= pb_val;
				@(negedge CLK_50M);
				case (s[9:8])
					2'd0: ex_arx = 13'd4;
					2'd1: ex_arx = 13'd0;
					2'd2: ex_arx = 13'd1;
					default: ex_arx = 13'd2;
				endcase
				ex_ary = (s[9:8] == 2'd0) ? 13'd3 : 13'd0;
				ex_frame = (s[13:12] == 2'b11) ? 2'd2 : s[13:12];
				dip = s[4] ? dip_mda : dip_cga;
				check_value("video_arx", video_arx, ex_arx);
				check_value("video_ary", video_ary, ex_ary);
				check_value("machine_model", machine_model, s[3]);
				check_value("video_card", video_card, s[4]);
				check_value("display_tint", display_tint, s[16:14]);
				check_value("ems_enable", ems_enable, !s[11]);
				check_value("ems_frame", ems_frame, ex_frame);
				check_value("adlib_hide", adlib_hide, s[10]);
				check_value("covox_enable", covox_enable, s[18]);
				check_value("port_c_low", port_c_low, pb_val[3] ? dip[7:4] : dip[3:0]);
			end
		end
	endtask

	// 0 soft reset, 1 user button, 2 BIOS download, 3 other download slot
	task reset_request_sources();
		int n;
		@(posedge CLK_50M);
		status <= 32'h1 << st_splash_skip;
		port_b_out <= 8'h00;
		wait_reset_level(1'b1, 1'b0, 300, n);
		for (int kind = 0; kind < 4; kind++) begin
			@(posedge CLK_50M);
			case (kind)
				0: status <= (32'h1 << st_splash_skip) | (32'h1 << st_soft_reset);
				1: user_button <= 1'b1;
				default: begin
					ioctl_download <= 1'b1;
					ioctl_index <= (kind == 2) ? 8'd0 : 8'd5;
				end
			endcase
			@(negedge CLK_50M);
			check_value("sys_reset before edge", sys_reset, 1'b0);
			@(negedge CLK_50M);
			check_value("sys_reset", sys_reset, kind != 3);
			check_value("cpu_reset", cpu_reset, kind != 3);
			repeat (3) @(negedge CLK_50M);
			check_value("cpu_reset held", cpu_reset, kind != 3);
			@(posedge CLK_50M);
			status <= 32'h1 << st_splash_skip;
			user_button <= 1'b0;
			ioctl_download <= 1'b0;
			wait_reset_level(1'b1, 1'b0, 300, n);
		end
	endtask

	// Pulse count over a fixed window
	task audio_pulse_rate();
		longint lo;
		int count;
		logic prev;
		lo = (longint'(50000) * audio_rate_hz) / sys_clock_hz;
		count = 0;
		prev = 1'b0;
		repeat (50000) begin
			@(negedge CLK_50M);
			check_value("audio_ce double pulse", prev & audio_ce, 1'b0);
			if (audio_ce)
				count++;
			prev = audio_ce;
		end
		check_value("audio_ce pulse count", count, (count == lo + 1) ? lo + 1 : lo);
	endtask

	task mount_image(input logic [63:0] size);
		@(posedge CLK_50M);
		img_size <= size;
		img_mounted <= 1'b1;
		@(posedge CLK_50M);
		img_mounted <= 1'b0;
	endtask

	// Random SPI levels against the expected steering
	task sweep_spi_levels(input logic virt);
		logic [4:0] r;
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			@(posedge CLK_50M);
			{spi_cs, spi_sck, spi_mosi, sd_miso, vsd_miso} <= r;
			@(negedge CLK_50M);
			check_value("sd_cs", sd_cs, virt ? 1'b1 : r[4]);
			check_value("sd_sck", sd_sck, virt ? 1'b0 : r[3]);
			check_value("sd_mosi", sd_mosi, virt ? 1'b0 : r[2]);
			check_value("vsd_cs", vsd_cs, virt ? r[4] : 1'b1);
			check_value("spi_miso", spi_miso, virt ? r[0] : r[1]);
		end
	endtask

	task sd_card_routing();
		mount_image(64'h0000_0000_0040_0000);
		sweep_spi_levels(1'b1);
		mount_image(64'h0);
		sweep_spi_levels(1'b0);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		seed = 10520;
		reset_wire = 1'b1;
		status = 32'h0;
		user_button = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		port_b_out = 8'h00;
		img_mounted = 1'b0;
		img_size = 64'h0;
		spi_cs = 1'b1;
		spi_sck = 1'b0;
		spi_mosi = 1'b0;
		sd_miso = 1'b0;
		vsd_miso = 1'b0;
		skipped_splash_release();
		splash_hold_time();
		decode_settings();
		reset_request_sources();
		audio_pulse_rate();
		sd_card_routing();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
pcxt_cfg_pkg.sv
pcxt_timing_pkg.sv
status_decode.sv
splash_timer.sv
reset_sequencer.sv
audio_tick_gen.sv
sd_route.sv
pcxt_glue_top.sv
tb_pcxt_glue.sv

/* Bender.yml */
package:
  name: pcxt_glue

sources:
  - pcxt_cfg_pkg.sv
  - pcxt_timing_pkg.sv
  - status_decode.sv
  - splash_timer.sv
  - reset_sequencer.sv
  - audio_tick_gen.sv
  - sd_route.sv
  - pcxt_glue_top.sv
  - target: test
    files:
      - tb_pcxt_glue.sv
